// ==== files.f ====
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_data_mem.sv
hw/rv_core.sv
test/rv_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator, from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f files.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rv_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== test/program.hex ====
// one instruction word per line, hex, then byte address and mnemonic
// x31 holds the uart address, x3 holds the 0xEE marker in the control section
00020FB7 // 000 lui   x31, 0x20
020F8F93 // 004 addi  x31, x31, 32
06400093 // 008 addi  x1, x0, 100
02500113 // 00C addi  x2, x0, 37
002081B3 // 010 add   x3, x1, x2
003F8023 // 014 sb    x3, 0(x31)
40208233 // 018 sub   x4, x1, x2
004F8023 // 01C sb    x4, 0(x31)
0020F2B3 // 020 and   x5, x1, x2
005F8023 // 024 sb    x5, 0(x31)
0020E333 // 028 or    x6, x1, x2
006F8023 // 02C sb    x6, 0(x31)
0020C3B3 // 030 xor   x7, x1, x2
007F8023 // 034 sb    x7, 0(x31)
FFB00413 // 038 addi  x8, x0, -5
001424B3 // 03C slt   x9, x8, x1
00143533 // 040 sltu  x10, x8, x1
009F8023 // 044 sb    x9, 0(x31)
00AF8023 // 048 sb    x10, 0(x31)
0FF0C613 // 04C xori  x12, x1, 255
00CF8023 // 050 sb    x12, 0(x31)
05016693 // 054 ori   x13, x2, 0x50
00DF8023 // 058 sb    x13, 0(x31)
00F0F713 // 05C andi  x14, x1, 15
FFC42793 // 060 slti  x15, x8, -4
0650B813 // 064 sltiu x16, x1, 101
00479893 // 068 slli  x17, x15, 4
00581913 // 06C slli  x18, x16, 5
0128E8B3 // 070 or    x17, x17, x18
00E8E8B3 // 074 or    x17, x17, x14
011F8023 // 078 sb    x17, 0(x31)
B2E00993 // 07C addi  x19, x0, -1234
00399A13 // 080 slli  x20, x19, 3
014F8023 // 084 sb    x20, 0(x31)
01C9DA93 // 088 srli  x21, x19, 28
015F8023 // 08C sb    x21, 0(x31)
41C9DB13 // 090 srai  x22, x19, 28
016F8023 // 094 sb    x22, 0(x31)
00200B93 // 098 addi  x23, x0, 2
01711C33 // 09C sll   x24, x2, x23
018F8023 // 0A0 sb    x24, 0(x31)
4179DCB3 // 0A4 sra   x25, x19, x23
019F8023 // 0A8 sb    x25, 0(x31)
ABCDED37 // 0AC lui   x26, 0xABCDE
00CD5D13 // 0B0 srli  x26, x26, 12
01AF8023 // 0B4 sb    x26, 0(x31)
00000D97 // 0B8 auipc x27, 0
01BF8023 // 0BC sb    x27, 0(x31)
8081FE37 // 0C0 lui   x28, 0x8081F
2A3E0E13 // 0C4 addi  x28, x28, 0x2A3
11C02023 // 0C8 sw    x28, 256(x0)
10000E83 // 0CC lb    x29, 256(x0)
004EDF13 // 0D0 srli  x30, x29, 4
01EF8023 // 0D4 sb    x30, 0(x31)
10004E83 // 0D8 lbu   x29, 256(x0)
004EDF13 // 0DC srli  x30, x29, 4
01EF8023 // 0E0 sb    x30, 0(x31)
10100E83 // 0E4 lb    x29, 257(x0)
004EDF13 // 0E8 srli  x30, x29, 4
01EF8023 // 0EC sb    x30, 0(x31)
10104E83 // 0F0 lbu   x29, 257(x0)
004EDF13 // 0F4 srli  x30, x29, 4
01EF8023 // 0F8 sb    x30, 0(x31)
10200E83 // 0FC lb    x29, 258(x0)
004EDF13 // 100 srli  x30, x29, 4
01EF8023 // 104 sb    x30, 0(x31)
10204E83 // 108 lbu   x29, 258(x0)
004EDF13 // 10C srli  x30, x29, 4
01EF8023 // 110 sb    x30, 0(x31)
10300E83 // 114 lb    x29, 259(x0)
004EDF13 // 118 srli  x30, x29, 4
01EF8023 // 11C sb    x30, 0(x31)
10304E83 // 120 lbu   x29, 259(x0)
004EDF13 // 124 srli  x30, x29, 4
01EF8023 // 128 sb    x30, 0(x31)
10001E83 // 12C lh    x29, 256(x0)
00CEDF13 // 130 srli  x30, x29, 12
01EF8023 // 134 sb    x30, 0(x31)
10005E83 // 138 lhu   x29, 256(x0)
00CEDF13 // 13C srli  x30, x29, 12
01EF8023 // 140 sb    x30, 0(x31)
10201E83 // 144 lh    x29, 258(x0)
00CEDF13 // 148 srli  x30, x29, 12
01EF8023 // 14C sb    x30, 0(x31)
10205E83 // 150 lhu   x29, 258(x0)
00CEDF13 // 154 srli  x30, x29, 12
01EF8023 // 158 sb    x30, 0(x31)
10002E83 // 15C lw    x29, 256(x0)
010EDF13 // 160 srli  x30, x29, 16
01EF8023 // 164 sb    x30, 0(x31)
00500093 // 168 addi  x1, x0, 5
00500113 // 16C addi  x2, x0, 5
0EE00193 // 170 addi  x3, x0, 0xEE
00208463 // 174 beq   x1, x2, +8
003F8023 // 178 sb    x3, 0(x31)
00809463 // 17C bne   x1, x8, +8
003F8023 // 180 sb    x3, 0(x31)
00144463 // 184 blt   x8, x1, +8
003F8023 // 188 sb    x3, 0(x31)
0080D463 // 18C bge   x1, x8, +8
003F8023 // 190 sb    x3, 0(x31)
0080E463 // 194 bltu  x1, x8, +8
003F8023 // 198 sb    x3, 0(x31)
00147463 // 19C bgeu  x8, x1, +8
003F8023 // 1A0 sb    x3, 0(x31)
0080006F // 1A4 jal   x0, +8
003F8023 // 1A8 sb    x3, 0(x31)
00300213 // 1AC addi  x4, x0, 3
004F8023 // 1B0 sb    x4, 0(x31)
FFF20213 // 1B4 addi  x4, x4, -1
FE021CE3 // 1B8 bne   x4, x0, -8
00C002EF // 1BC jal   x5, +12
006F8023 // 1C0 sb    x6, 0(x31)
0100006F // 1C4 jal   x0, +16
01028313 // 1C8 addi  x6, x5, 16
00028067 // 1CC jalr  x0, 0(x5)
003F8023 // 1D0 sb    x3, 0(x31)
00A00393 // 1D4 addi  x7, x0, 10
007F8023 // 1D8 sb    x7, 0(x31)
0000006F // 1DC jal   x0, 0

// ==== test/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam int N_BYTES        = 35;
    localparam int STROBE_TIMEOUT = 500;
    localparam int QUIET_CYCLES   = 200;

    logic       clk;
    logic       reset;
    logic       o_uart_en;
    logic [7:0] o_uart_data;

    int error_count = 0;
    int received    = 0;
    bit timed_out   = 0;
    bit seen;

    // bytes in the order program.hex sends them
    logic [7:0] expected_bytes [0:N_BYTES-1] = '{
        8'h89, 8'h3F, 8'h24, 8'h65, 8'h41, 8'h01, 8'h00, 8'h9B, // alu
        8'h75, 8'h34,
        8'h70, 8'h0F, 8'hFF, 8'h94, 8'hCB, 8'hDE, 8'hB8,        // shifts, lui, auipc
        8'hFA, 8'h0A, 8'hFF, 8'h0F, 8'hF8, 8'h08, 8'hF8, 8'h08, // lb/lbu per lane
        8'hFF, 8'h0F, 8'hF8, 8'h08,                             // lh/lhu
        8'h81,                                                  // lw
        8'h03, 8'h02, 8'h01,                                    // countdown
        8'hD0,                                                  // jalr link
        8'h0A
    };

    rv_core i_dut (
        .clk         (clk),
        .reset       (reset),
        .o_uart_en   (o_uart_en),
        .o_uart_data (o_uart_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_byte(input logic [7:0] exp, input logic [7:0] act, input int idx);
        if (act !== exp) begin
            error_count++;
            $display("Fail %0t o_uart_data byte %0d expected %h got %h", $time, idx, exp, act);
        end
    endtask

    task automatic check_count(input int exp, input int act, input string name);
        if (act != exp) begin
            error_count++;
            $display("Fail %0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic compare_level(input logic exp, input logic act, input string name);
        if (act !== exp) begin
            error_count++;
            $display("Fail %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // polls o_uart_en on each falling edge
    task automatic wait_for_strobe(output bit found);
        int cycles;
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < STROBE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (o_uart_en === 1'b1) found = 1'b1;
        end
    endtask

    initial begin
        reset = 1'b1;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            compare_level(1'b0, o_uart_en, "o_uart_en during reset");
        end
        reset = 1'b0;

        for (int i = 0; i < N_BYTES; i++) begin
            wait_for_strobe(seen);
            if (!seen) begin
                error_count++;
                timed_out = 1'b1;
                $display("timeout at %0t: uart byte %0d never arrived", $time, i);
                break;
            end
            received++;
            check_byte(expected_bytes[i], o_uart_data, i);
        end

        if (!timed_out) begin
            for (int c = 0; c < QUIET_CYCLES; c++) begin // program should spin silently
                @(negedge clk);
                if (o_uart_en === 1'b1) begin
                    received++;
                    $display("extra uart strobe at %0t with data %h", $time, o_uart_data);
                end
            end
            check_count(N_BYTES, received, "uart strobe count");
        end

        $display("error count: %0d", error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    output logic       o_uart_en,
    output logic [7:0] o_uart_data
);

    if_de_t          if_de;
    de_ex_t          de_ex;
    ex_mem_t         ex_mem;
    wb_t             wb;
    logic            stall;
    logic            jump;
    logic [XLEN-1:0] jump_addr;

    rv_fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .i_stall     (stall),
        .i_jump      (jump),
        .i_jump_addr (jump_addr),
        .o_if_de     (if_de)
    );

    rv_decode u_decode (
        .clk     (clk),
        .reset   (reset),
        .i_if_de (if_de),
        .i_jump  (jump),
        .i_wb    (wb),
        .o_de_ex (de_ex),
        .o_stall (stall)
    );

    rv_execute u_execute (
        .clk         (clk),
        .reset       (reset),
        .i_de_ex     (de_ex),
        .i_wb        (wb),
        .o_ex_mem    (ex_mem),
        .o_jump      (jump),
        .o_jump_addr (jump_addr),
        .o_uart_en   (o_uart_en),
        .o_uart_data (o_uart_data)
    );

    rv_data_mem u_data_mem (
        .clk      (clk),
        .reset    (reset),
        .i_ex_mem (ex_mem),
        .o_wb     (wb)
    );

endmodule

`default_nettype wire

// ==== hw/rv_data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_data_mem import rv_pkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  wire ex_mem_t i_ex_mem,
    output wb_t          o_wb
);

    logic [3:0][7:0]       dmem [0:DMEM_WORDS-1];
    logic [XLEN-1:0]       rdata;
    logic                  wb_en_q;
    logic                  is_load_q;
    logic                  signed_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic [3:0]            mask_q;
    logic [XLEN-1:0]       result_q;
    logic [XLEN-1:0]       shifted;
    logic [XLEN-1:0]       load_val;

    always_ff @(posedge clk) begin
        if (i_ex_mem.store_en) begin
            for (int i = 0; i < 4; i++) begin
                if (i_ex_mem.byte_mask[i]) begin
                    dmem[i_ex_mem.word_addr][i] <= i_ex_mem.store_data[8*i +: 8];
                end
            end
        end
        rdata     <= dmem[i_ex_mem.word_addr];
        is_load_q <= i_ex_mem.is_load;
        signed_q  <= i_ex_mem.load_signed;
        rd_q      <= i_ex_mem.rd;
        mask_q    <= i_ex_mem.byte_mask;
        result_q  <= i_ex_mem.result;
        wb_en_q   <= reset ? 1'b0 : i_ex_mem.wb_en;
    end

    // move the lowest selected lane down to bit 0
    always_comb begin
        case (mask_q)
            4'b0010:          shifted = {8'h00, rdata[31:8]};
            4'b0100, 4'b1100: shifted = {16'h0000, rdata[31:16]};
            4'b1000:          shifted = {24'h000000, rdata[31:24]};
            default:          shifted = rdata;
        endcase
        case (mask_q)
            4'b0001, 4'b0010, 4'b0100, 4'b1000:
                load_val = {{24{signed_q & shifted[7]}}, shifted[7:0]};
            4'b0011, 4'b1100:
                load_val = {{16{signed_q & shifted[15]}}, shifted[15:0]};
            default:
                load_val = shifted;
        endcase
    end

    assign o_wb.wb_en = wb_en_q;
    assign o_wb.rd    = rd_q;
    assign o_wb.data  = is_load_q ? load_val : result_q;

endmodule

`default_nettype wire

// ==== hw/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_pkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire de_ex_t     i_de_ex,
    input  wire wb_t        i_wb,
    output ex_mem_t         o_ex_mem,
    output logic            o_jump,
    output logic [XLEN-1:0] o_jump_addr,
    output logic            o_uart_en,
    output logic [7:0]      o_uart_data
);

    logic [5:0]      op;
    logic [XLEN-1:0] opa;
    logic [XLEN-1:0] opb;
    logic [XLEN-1:0] opb_alu;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] store_data;
    logic [3:0]      mask;
    logic            take;
    logic            writes;
    logic            is_load;
    logic            is_store;
    logic            uart_hit;
    ex_mem_t         ex_next;

    // a load still in memory cannot be forwarded, its data shows up on write-back
    function automatic logic [XLEN-1:0] fwd(input logic [REG_ADDR_W-1:0] rs,
                                            input logic [XLEN-1:0] val,
                                            input ex_mem_t mem, input wb_t wb);
        if (mem.wb_en && !mem.is_load && mem.rd == rs) return mem.result;
        if (wb.wb_en && wb.rd == rs) return wb.data;
        return val;
    endfunction

    assign op      = i_de_ex.valid ? i_de_ex.op : OP_NOP;
    assign opa     = fwd(i_de_ex.rs1, i_de_ex.a, o_ex_mem, i_wb);
    assign opb     = fwd(i_de_ex.rs2, i_de_ex.b, o_ex_mem, i_wb);
    assign opb_alu = (op inside {OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
                                 OP_SLLI, OP_SRLI, OP_SRAI}) ? i_de_ex.imm : opb;
    assign addr    = opa + i_de_ex.imm;

    always_comb begin
        result = '0;
        take   = 1'b0;
        case (op)
            OP_ADD, OP_ADDI:   result = opa + opb_alu;
            OP_SUB:            result = opa - opb;
            OP_AND, OP_ANDI:   result = opa & opb_alu;
            OP_OR, OP_ORI:     result = opa | opb_alu;
            OP_XOR, OP_XORI:   result = opa ^ opb_alu;
            OP_SLL, OP_SLLI:   result = opa << opb_alu[4:0];
            OP_SRL, OP_SRLI:   result = opa >> opb_alu[4:0];
            OP_SRA, OP_SRAI:   result = $signed(opa) >>> opb_alu[4:0];
            OP_SLT, OP_SLTI:   result = XLEN'($signed(opa) < $signed(opb_alu));
            OP_SLTU, OP_SLTIU: result = XLEN'(opa < opb_alu);
            OP_LUI:            result = i_de_ex.imm;
            OP_AUIPC:          result = i_de_ex.pc + i_de_ex.imm;
            OP_JAL, OP_JALR: begin
                result = i_de_ex.pc + 32'd4; // link
                take   = 1'b1;
            end
            OP_BEQ:  take = (opa == opb);
            OP_BNE:  take = (opa != opb);
            OP_BLT:  take = ($signed(opa) < $signed(opb));
            OP_BGE:  take = ($signed(opa) >= $signed(opb));
            OP_BLTU: take = (opa < opb);
            OP_BGEU: take = (opa >= opb);
            default: result = '0;
        endcase
    end

    assign o_jump      = take;
    assign o_jump_addr = (op == OP_JALR) ? {addr[XLEN-1:1], 1'b0} : i_de_ex.pc + i_de_ex.imm;

    // lanes replicated so the mask alone picks the bytes written
    always_comb begin
        case (op)
            OP_LB, OP_LBU, OP_SB: begin
                mask       = 4'b0001 << addr[1:0];
                store_data = {4{opb[7:0]}};
            end
            OP_LH, OP_LHU, OP_SH: begin
                mask       = 4'b0011 << {addr[1], 1'b0};
                store_data = {2{opb[15:0]}};
            end
            default: begin
                mask       = 4'b1111;
                store_data = opb;
            end
        endcase
    end

    assign is_load  = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    assign is_store = op inside {OP_SB, OP_SH, OP_SW};
    assign uart_hit = (op == OP_SB) && (addr == UART_TX_ADDR);
    assign writes   = !(is_store || op inside {OP_NOP, OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
                                              OP_BLTU, OP_BGEU});

    assign ex_next = '{
        wb_en:       writes && i_de_ex.rd != '0,
        is_load:     is_load,
        rd:          i_de_ex.rd,
        result:      is_load ? addr : result,
        word_addr:   addr[DMEM_AW+1:2],
        byte_mask:   mask,
        load_signed: op inside {OP_LB, OP_LH},
        store_en:    is_store && !uart_hit, // uart byte stays out of data memory
        store_data:  store_data
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            o_ex_mem.wb_en    <= 1'b0;
            o_ex_mem.is_load  <= 1'b0;
            o_ex_mem.store_en <= 1'b0;
            o_uart_en         <= 1'b0;
        end else begin
            o_ex_mem  <= ex_next;
            o_uart_en <= uart_hit;
        end
        o_uart_data <= opb[7:0];
    end

endmodule

`default_nettype wire

// ==== hw/rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire if_de_t i_if_de,
    input  wire         i_jump,
    input  wire wb_t    i_wb,
    output de_ex_t      o_de_ex,
    output logic        o_stall
);

    logic [XLEN-1:0]       regs [1:31]; // x0 is not stored
    inst_t                 inst;
    logic [6:0]            opc;
    logic [2:0]            f3;
    logic [6:0]            f7;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [5:0]            op;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
    logic                  ex_load;
    de_ex_t                de_next;

    assign inst = i_if_de.inst;
    assign opc  = inst.r_fmt.opcode;
    assign f3   = inst.r_fmt.funct3;
    assign f7   = inst.r_fmt.funct7;
    assign rs1  = inst.r_fmt.rs1;
    assign rs2  = inst.r_fmt.rs2;

    always_comb begin
        op = OP_NOP; // fence, system and unknown opcodes
        case (opc)
            OPC_LUI:    op = OP_LUI;
            OPC_AUIPC:  op = OP_AUIPC;
            OPC_JAL:    op = OP_JAL;
            OPC_JALR:   op = (f3 == 3'b000) ? OP_JALR : OP_NOP;
            OPC_BRANCH: case (f3)
                3'b000:  op = OP_BEQ;
                3'b001:  op = OP_BNE;
                3'b100:  op = OP_BLT;
                3'b101:  op = OP_BGE;
                3'b110:  op = OP_BLTU;
                3'b111:  op = OP_BGEU;
                default: op = OP_NOP;
            endcase
            OPC_LOAD: case (f3)
                3'b000:  op = OP_LB;
                3'b001:  op = OP_LH;
                3'b010:  op = OP_LW;
                3'b100:  op = OP_LBU;
                3'b101:  op = OP_LHU;
                default: op = OP_NOP;
            endcase
            OPC_STORE: case (f3)
                3'b000:  op = OP_SB;
                3'b001:  op = OP_SH;
                3'b010:  op = OP_SW;
                default: op = OP_NOP;
            endcase
            OPC_OP_IMM: case (f3)
                3'b000:  op = OP_ADDI;
                3'b001:  op = OP_SLLI;
                3'b010:  op = OP_SLTI;
                3'b011:  op = OP_SLTIU;
                3'b100:  op = OP_XORI;
                3'b101:  op = f7[5] ? OP_SRAI : OP_SRLI;
                3'b110:  op = OP_ORI;
                default: op = OP_ANDI;
            endcase
            OPC_OP: if (!f7[0]) begin // funct7 bit 0 marks the m extension
                case (f3)
                    3'b000:  op = f7[5] ? OP_SUB : OP_ADD;
                    3'b001:  op = OP_SLL;
                    3'b010:  op = OP_SLT;
                    3'b011:  op = OP_SLTU;
                    3'b100:  op = OP_XOR;
                    3'b101:  op = f7[5] ? OP_SRA : OP_SRL;
                    3'b110:  op = OP_OR;
                    default: op = OP_AND;
                endcase
            end
            default: op = OP_NOP;
        endcase
    end

    always_comb begin
        case (opc)
            OPC_LUI, OPC_AUIPC: imm = {inst.u_fmt.imm, 12'h000};
            OPC_JAL: imm = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
                            inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};
            OPC_BRANCH: imm = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
                               inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
            OPC_STORE: imm = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
            default: imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
        endcase
    end

    // register read with write-through from write-back
    always_comb begin
        rs1_val = (rs1 == '0) ? '0 : regs[rs1];
        rs2_val = (rs2 == '0) ? '0 : regs[rs2];
        if (i_wb.wb_en && i_wb.rd == rs1 && rs1 != '0) rs1_val = i_wb.data;
        if (i_wb.wb_en && i_wb.rd == rs2 && rs2 != '0) rs2_val = i_wb.data;
    end

    always_ff @(posedge clk) begin
        if (i_wb.wb_en && i_wb.rd != '0) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    assign ex_load = o_de_ex.valid && (o_de_ex.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU});
    assign o_stall = i_if_de.valid && ex_load && o_de_ex.rd != '0
                     && (o_de_ex.rd == rs1 || o_de_ex.rd == rs2);

    assign de_next = '{
        valid: i_if_de.valid,
        op:    op,
        a:     rs1_val,
        b:     rs2_val,
        imm:   imm,
        rs1:   rs1,
        rs2:   rs2,
        rd:    inst.r_fmt.rd,
        pc:    i_if_de.pc
    };

    always_ff @(posedge clk) begin
        if (reset || i_jump || o_stall) begin
            o_de_ex.valid <= 1'b0; // bubble
        end else begin
            o_de_ex <= de_next;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_fetch import rv_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    input  wire            i_stall,
    input  wire            i_jump,
    input  wire [XLEN-1:0] i_jump_addr,
    output if_de_t         o_if_de
);

    logic [XLEN-1:0] imem [0:IMEM_WORDS-1];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;

    initial begin
        $readmemh(PROGRAM_FILE, imem);
    end

    // jump wins over a load-use hold
    always_comb begin
        if (i_jump) begin
            pc_next = i_jump_addr;
        end else if (i_stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc            <= '0;
            o_if_de.valid <= 1'b0;
        end else begin
            pc <= pc_next;
            if (i_jump) begin
                o_if_de.valid <= 1'b0; // squash the wrong-path fetch
            end else if (!i_stall) begin
                o_if_de.pc    <= pc;
                o_if_de.inst  <= imem[pc[IMEM_AW+1:2]];
                o_if_de.valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    localparam PROGRAM_FILE = "test/program.hex";
    localparam logic [XLEN-1:0] UART_TX_ADDR = 32'h0002_0020;

    // rv32i major opcodes
    localparam logic [6:0]
        OPC_LUI    = 7'b0110111, OPC_AUIPC = 7'b0010111, OPC_JAL   = 7'b1101111,
        OPC_JALR   = 7'b1100111, OPC_BRANCH = 7'b1100011, OPC_LOAD = 7'b0000011,
        OPC_STORE  = 7'b0100011, OPC_OP_IMM = 7'b0010011, OPC_OP   = 7'b0110011;

    // internal operation codes, one per instruction
    localparam logic [5:0]
        OP_NOP  = 6'd0,  OP_LUI  = 6'd1,  OP_AUIPC = 6'd2,  OP_JAL   = 6'd3,
        OP_JALR = 6'd4,  OP_BEQ  = 6'd5,  OP_BNE   = 6'd6,  OP_BLT   = 6'd7,
        OP_BGE  = 6'd8,  OP_BLTU = 6'd9,  OP_BGEU  = 6'd10, OP_LB    = 6'd11,
        OP_LH   = 6'd12, OP_LW   = 6'd13, OP_LBU   = 6'd14, OP_LHU   = 6'd15,
        OP_SB   = 6'd16, OP_SH   = 6'd17, OP_SW    = 6'd18, OP_ADDI  = 6'd19,
        OP_SLTI = 6'd20, OP_SLTIU = 6'd21, OP_XORI = 6'd22, OP_ORI   = 6'd23,
        OP_ANDI = 6'd24, OP_SLLI = 6'd25, OP_SRLI  = 6'd26, OP_SRAI  = 6'd27,
        OP_ADD  = 6'd28, OP_SUB  = 6'd29, OP_SLL   = 6'd30, OP_SLT   = 6'd31,
        OP_SLTU = 6'd32, OP_XOR  = 6'd33, OP_SRL   = 6'd34, OP_SRA   = 6'd35,
        OP_OR   = 6'd36, OP_AND  = 6'd37;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } inst_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        inst_t           inst;
        logic            valid;
    } if_de_t;

    typedef struct packed {
        logic                  valid;
        logic [5:0]            op;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       pc;
    } de_ex_t;

    typedef struct packed {
        logic                  wb_en;
        logic                  is_load;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
        logic [DMEM_AW-1:0]    word_addr;
        logic [3:0]            byte_mask;
        logic                  load_signed;
        logic                  store_en;
        logic [XLEN-1:0]       store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                  wb_en;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

`default_nettype wire
